/* include/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Byte address width of both ports.
`define MEM_ADDR_W 64

// One memory word holds a doubleword.
`define MEM_DATA_W 64

// 1024 words, 8 KiB window.
`define MEM_DEPTH_LOG2 10

`define MEM_BASE 64'h0000_0000_8000_0000

`endif

/* logic/mem_op_pkg.sv */
package mem_op_pkg;

    // Bit 2 set means zero extension on a load.
    typedef enum logic [2:0] {
        OP_B  = 3'd0,
        OP_H  = 3'd1,
        OP_W  = 3'd2,
        OP_D  = 3'd3,
        OP_BU = 3'd4,
        OP_HU = 3'd5,
        OP_WU = 3'd6
    } mem_op_e;

    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2,
        SZ_D = 2'd3
    } mem_size_e;

    // Byte position inside a memory word.
    typedef logic [2:0] byte_off_t;

    function automatic mem_size_e op_size(mem_op_e op);
        case (op)
            OP_B, OP_BU: return SZ_B;
            OP_H, OP_HU: return SZ_H;
            OP_W, OP_WU: return SZ_W;
            default:     return SZ_D; // OP_D and the unused code.
        endcase
    endfunction

endpackage

/* logic/mem_bus_pkg.sv */
`include "mem_defs.svh"

package mem_bus_pkg;
    import mem_op_pkg::*;

    typedef struct packed {
        logic                   en;
        logic [`MEM_ADDR_W-1:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic        error;
        logic [31:0] instr;
    } fetch_rsp_t;

    // rd and wr both set is a store.
    typedef struct packed {
        logic                   rd;
        logic                   wr;
        mem_op_e                op;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] wdata;
    } data_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   error;
        logic [`MEM_DATA_W-1:0] rdata;
    } data_rsp_t;

    typedef struct packed {
        logic                       fetch_en;
        logic [`MEM_DEPTH_LOG2-1:0] fetch_idx;
        logic                       data_en;
        logic                       data_we;
        logic [`MEM_DEPTH_LOG2-1:0] data_idx;
    } ram_cmd_t;

    // Captured with the request, used by the read datapath one cycle later.
    typedef struct packed {
        mem_op_e   op;
        byte_off_t off;
        logic      pc_hi;
    } align_info_t;

endpackage

/* logic/mem_ctrl.sv */
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_ctrl
    import mem_op_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  fetch_req_t  fetch_req,
    input  data_req_t   data_req,
    output ram_cmd_t    ram_cmd,
    output align_info_t align_info,
    output logic        fetch_valid,
    output logic        fetch_error,
    output logic        data_valid,
    output logic        data_error
);

    localparam int IDX_LO = 3;
    localparam int IDX_HI = `MEM_DEPTH_LOG2 + 2;

    logic [`MEM_ADDR_W-1:0] fetch_off;
    logic [`MEM_ADDR_W-1:0] data_off;
    logic                   fetch_bad;
    logic                   data_bad;
    logic                   data_misal;
    logic                   data_act;

    // Below the base wraps around and lands out of range too.
    assign fetch_off = fetch_req.pc - `MEM_BASE;
    assign data_off  = data_req.addr - `MEM_BASE;

    assign data_act = data_req.rd | data_req.wr;

    always_comb begin
        case (op_size(data_req.op))
            SZ_B:    data_misal = 1'b0;
            SZ_H:    data_misal = data_req.addr[0];
            SZ_W:    data_misal = |data_req.addr[1:0];
            default: data_misal = |data_req.addr[2:0];
        endcase
    end

    assign fetch_bad = (|fetch_off[`MEM_ADDR_W-1:IDX_HI+1]) | (|fetch_req.pc[1:0]);
    assign data_bad  = (|data_off[`MEM_ADDR_W-1:IDX_HI+1]) | data_misal;

    always_comb begin
        ram_cmd.fetch_en  = fetch_req.en & ~fetch_bad;
        ram_cmd.fetch_idx = fetch_off[IDX_HI:IDX_LO];
        ram_cmd.data_en   = data_act & ~data_bad;
        ram_cmd.data_we   = data_req.wr & ~data_bad; // Bad stores never reach the array.
        ram_cmd.data_idx  = data_off[IDX_HI:IDX_LO];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
            fetch_error <= 1'b0;
            data_valid  <= 1'b0;
            data_error  <= 1'b0;
            align_info  <= '0;
        end else begin
            fetch_valid      <= fetch_req.en;
            fetch_error      <= fetch_req.en & fetch_bad;
            data_valid       <= data_act;
            data_error       <= data_act & data_bad;
            align_info.op    <= data_req.op;
            align_info.off   <= data_req.addr[2:0];
            align_info.pc_hi <= fetch_req.pc[2];
        end
    end

endmodule

/* logic/word_ram.sv */
`timescale 1ns/100ps
`include "mem_defs.svh"

module word_ram
    import mem_bus_pkg::*;
(
    input  logic                   clk,
    input  ram_cmd_t               ram_cmd,
    input  logic [7:0]             byte_en,
    input  logic [`MEM_DATA_W-1:0] wdata,
    output logic [`MEM_DATA_W-1:0] fetch_word,
    output logic [`MEM_DATA_W-1:0] data_word
);

    localparam int DEPTH = 1 << `MEM_DEPTH_LOG2;

    logic [`MEM_DATA_W-1:0] mem [0:DEPTH-1];

    // Fetch port is read only.
    always_ff @(posedge clk) begin
        if (ram_cmd.fetch_en) begin
            fetch_word <= mem[ram_cmd.fetch_idx];
        end
    end

    // Read before write, a same-cycle load sees the old word.
    always_ff @(posedge clk) begin
        if (ram_cmd.data_en) begin
            data_word <= mem[ram_cmd.data_idx];
            if (ram_cmd.data_we) begin
                for (int i = 0; i < 8; i++) begin
                    if (byte_en[i]) begin
                        mem[ram_cmd.data_idx][i*8 +: 8] <= wdata[i*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

/* logic/read_align.sv */
`timescale 1ns/100ps
`include "mem_defs.svh"

module read_align
    import mem_op_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic [`MEM_DATA_W-1:0] fetch_word,
    input  logic [`MEM_DATA_W-1:0] data_word,
    input  align_info_t            align_info,
    input  logic                   fetch_error,
    input  logic                   data_error,
    output logic [31:0]            instr,
    output logic [`MEM_DATA_W-1:0] rdata
);

    logic [7:0]             b_lane;
    logic [15:0]            h_lane;
    logic [31:0]            w_lane;
    logic [`MEM_DATA_W-1:0] load_val;
    logic [31:0]            instr_half;

    // Lanes of a naturally aligned access, low address bits pick the lane.
    always_comb begin
        b_lane = data_word[{align_info.off, 3'b000} +: 8];
        h_lane = data_word[{align_info.off[2:1], 4'b0000} +: 16];
        w_lane = data_word[{align_info.off[2], 5'b00000} +: 32];
    end

    always_comb begin
        case (align_info.op)
            OP_B:    load_val = {{(`MEM_DATA_W-8){b_lane[7]}}, b_lane};
            OP_BU:   load_val = {{(`MEM_DATA_W-8){1'b0}}, b_lane};
            OP_H:    load_val = {{(`MEM_DATA_W-16){h_lane[15]}}, h_lane};
            OP_HU:   load_val = {{(`MEM_DATA_W-16){1'b0}}, h_lane};
            OP_W:    load_val = {{(`MEM_DATA_W-32){w_lane[31]}}, w_lane};
            OP_WU:   load_val = {{(`MEM_DATA_W-32){1'b0}}, w_lane};
            default: load_val = data_word; // Doubleword.
        endcase
    end

    assign instr_half = align_info.pc_hi ? fetch_word[63:32] : fetch_word[31:0];

    // Errored accesses never read the array, so the word is stale.
    assign instr = fetch_error ? 32'h0 : instr_half;
    assign rdata = data_error ? '0 : load_val;

endmodule

/* logic/store_merge.sv */
`timescale 1ns/100ps
`include "mem_defs.svh"

module store_merge
    import mem_op_pkg::*;
    import mem_bus_pkg::*;
(
    input  data_req_t              data_req,
    output logic [7:0]             byte_en,
    output logic [`MEM_DATA_W-1:0] wdata
);

    byte_off_t  off;
    logic [7:0] size_mask;

    assign off = data_req.addr[2:0];

    // Replicating the low bytes puts them in every lane of that size.
    always_comb begin
        case (op_size(data_req.op))
            SZ_B: begin
                size_mask = 8'h01;
                wdata     = {8{data_req.wdata[7:0]}};
            end
            SZ_H: begin
                size_mask = 8'h03;
                wdata     = {4{data_req.wdata[15:0]}};
            end
            SZ_W: begin
                size_mask = 8'h0f;
                wdata     = {2{data_req.wdata[31:0]}};
            end
            default: begin
                size_mask = 8'hff;
                wdata     = data_req.wdata;
            end
        endcase
    end

    // Misaligned offsets may spill past lane 7, mem_ctrl blocks those writes anyway.
    assign byte_en = size_mask << off;

endmodule

/* logic/mem_subsystem.sv */
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_subsystem
    import mem_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  fetch_req_t fetch_req,
    input  data_req_t  data_req,
    output fetch_rsp_t fetch_rsp,
    output data_rsp_t  data_rsp
);

    ram_cmd_t               ram_cmd;
    align_info_t            align_info;
    logic                   fetch_valid;
    logic                   fetch_error;
    logic                   data_valid;
    logic                   data_error;
    logic [7:0]             byte_en;
    logic [`MEM_DATA_W-1:0] wdata;
    logic [`MEM_DATA_W-1:0] fetch_word;
    logic [`MEM_DATA_W-1:0] data_word;
    logic [`MEM_DATA_W-1:0] rdata;
    logic [31:0]            instr;

    mem_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .data_req    (data_req),
        .ram_cmd     (ram_cmd),
        .align_info  (align_info),
        .fetch_valid (fetch_valid),
        .fetch_error (fetch_error),
        .data_valid  (data_valid),
        .data_error  (data_error)
    );

    store_merge u_merge (
        .data_req (data_req),
        .byte_en  (byte_en),
        .wdata    (wdata)
    );

    word_ram u_ram (
        .clk        (clk),
        .ram_cmd    (ram_cmd),
        .byte_en    (byte_en),
        .wdata      (wdata),
        .fetch_word (fetch_word),
        .data_word  (data_word)
    );

    read_align u_align (
        .fetch_word  (fetch_word),
        .data_word   (data_word),
        .align_info  (align_info),
        .fetch_error (fetch_error),
        .data_error  (data_error),
        .instr       (instr),
        .rdata       (rdata)
    );

    assign fetch_rsp = '{valid: fetch_valid, error: fetch_error, instr: instr};
    assign data_rsp  = '{valid: data_valid, error: data_error, rdata: rdata};

endmodule

/* tb/mem_checker.sv */
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_checker
    import mem_bus_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input fetch_req_t fetch_req,
    input data_req_t  data_req,
    input fetch_rsp_t fetch_rsp,
    input data_rsp_t  data_rsp,
    input ram_cmd_t   ram_cmd
);

    logic                   data_act;
    logic [`MEM_ADDR_W-1:0] data_rel;
    logic [3:0]             size_mask;
    logic                   store_legal;

    assign data_act = data_req.rd | data_req.wr; // Any data port request.

    assign data_rel  = data_req.addr - `MEM_BASE;
    assign size_mask = (4'd1 << data_req.op[1:0]) - 4'd1; // Low opcode bits give log2 of the size.

    // In the window and naturally aligned for the access size.
    assign store_legal = (data_rel < (64'd8 << `MEM_DEPTH_LOG2)) &&
                         (({1'b0, data_req.addr[2:0]} & size_mask) == 4'd0);

    fetch_follows: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req.en |=> fetch_rsp.valid)
        else $error("fetch valid missing one cycle after a fetch request");

    fetch_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        !fetch_req.en |=> !fetch_rsp.valid)
        else $error("fetch valid raised without a fetch request");

    data_follows: assert property (@(posedge clk) disable iff (!rst_n)
        data_act |=> data_rsp.valid)
        else $error("data valid missing one cycle after a data request");

    data_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        !data_act |=> !data_rsp.valid)
        else $error("data valid raised without a data request");

    // Responses stay quiet while reset is held.
    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (!fetch_rsp.valid && !data_rsp.valid && !ram_cmd.data_we))
        else $error("valid or write enable active during reset");

    // Only an in-window aligned store may reach the array.
    no_bad_write: assert property (@(posedge clk) disable iff (!rst_n)
        ram_cmd.data_we |-> store_legal)
        else $error("write enabled for a store that is out of range or misaligned");

endmodule

/* tb/mem_tb.sv */
`timescale 1ns/100ps
`include "mem_defs.svh"

module mem_tb
    import mem_op_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int WINDOW  = 8 << `MEM_DEPTH_LOG2; // Window size in bytes.
    localparam int N_WORDS = 16;                   // Words that the tests touch.
    localparam int N_RAND  = 200;
    localparam int MARGIN  = 20;

    localparam fetch_req_t NO_FETCH = '0;
    localparam data_req_t  NO_DATA  = '0;

    typedef struct packed {
        fetch_req_t f_req;
        data_req_t  d_req;
        fetch_rsp_t f_exp;
        data_rsp_t  d_exp;
        logic       chk_rdata;
    } row_t;

    logic        clk;
    logic        rst_n;
    fetch_req_t  fetch_req;
    data_req_t   data_req;
    fetch_rsp_t  fetch_rsp;
    data_rsp_t   data_rsp;

    row_t        rows[$];
    logic [63:0] shadow [0:(1 << `MEM_DEPTH_LOG2)-1];
    int          seed;
    int          cycles = 0;
    int          cycle_limit;

    mem_subsystem dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp)
    );

    bind mem_subsystem mem_checker chk0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .fetch_rsp (fetch_rsp),
        .data_rsp  (data_rsp),
        .ram_cmd   (ram_cmd)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            $display("Something failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic int size_bytes(mem_op_e op);
        return 1 << op[1:0]; // Low two opcode bits give log2 of the size.
    endfunction

    function automatic logic [63:0] word_addr(int idx, int off);
        return `MEM_BASE + 64'(idx * 8 + off);
    endfunction

    function automatic int word_index(logic [63:0] addr);
        logic [63:0] rel;
        rel = addr - `MEM_BASE;
        return int'(rel >> 3);
    endfunction

    function automatic logic addr_ok(logic [63:0] addr, int size);
        logic [63:0] rel;
        rel = addr - `MEM_BASE;
        return (rel < 64'(WINDOW)) && ((addr % 64'(size)) == 64'd0);
    endfunction

    // Mixes every address bit into the initial word contents.
    function automatic logic [63:0] fill_pattern(logic [63:0] addr);
        return {addr[31:0] ^ 32'h9e37_79b9, ~addr[31:0]} ^ (addr << 13) ^ (addr >> 7);
    endfunction

    function automatic logic [63:0] load_expect(logic [63:0] word, mem_op_e op, logic [2:0] off);
        logic [63:0] v;
        logic [63:0] mask;
        int          n;
        n = size_bytes(op) * 8;
        v = word >> (int'(off) * 8);
        if (n < 64) begin
            mask = (64'd1 << n) - 64'd1;
            v    = v & mask;
            if (!op[2] && v[n-1]) begin
                v = v | ~mask; // Signed opcodes copy the lane's top bit upward.
            end
        end
        return v;
    endfunction

    function automatic fetch_req_t mk_fetch(logic en, logic [63:0] pc);
        fetch_req_t f;
        f.en = en;
        f.pc = pc;
        return f;
    endfunction

    function automatic data_req_t mk_data(logic rd, logic wr, mem_op_e op,
                                          logic [63:0] addr, logic [63:0] wdata);
        data_req_t d;
        d.rd    = rd;
        d.wr    = wr;
        d.op    = op;
        d.addr  = addr;
        d.wdata = wdata;
        return d;
    endfunction

    // Expected responses come from the shadow before this row's store lands.
    task automatic add_row(fetch_req_t f, data_req_t d);
        row_t        r;
        logic [63:0] old;
        logic        d_ok;
        int          idx;
        r = '0;
        r.f_req = f;
        r.d_req = d;
        if (f.en) begin
            r.f_exp.valid = 1'b1;
            r.f_exp.error = !addr_ok(f.pc, 4);
            if (!r.f_exp.error) begin
                old = shadow[word_index(f.pc)];
                r.f_exp.instr = f.pc[2] ? old[63:32] : old[31:0];
            end
        end
        if (d.rd || d.wr) begin
            d_ok = addr_ok(d.addr, size_bytes(d.op));
            r.d_exp.valid = 1'b1;
            r.d_exp.error = !d_ok;
            r.chk_rdata   = !d.wr || !d_ok;
            if (d_ok) begin
                idx = word_index(d.addr);
                if (d.wr) begin
                    for (int i = 0; i < size_bytes(d.op); i++) begin
                        shadow[idx][(int'(d.addr[2:0]) + i) * 8 +: 8] = d.wdata[i*8 +: 8];
                    end
                end else begin
                    r.d_exp.rdata = load_expect(shadow[idx], d.op, d.addr[2:0]);
                end
            end
        end
        rows.push_back(r);
    endtask

    task automatic store_then_load(mem_op_e op, int w, int off, logic [63:0] wd);
        add_row(NO_FETCH, mk_data(1'b0, 1'b1, op, word_addr(w, off), wd));
        add_row(NO_FETCH, mk_data(1'b1, 1'b0, OP_D, word_addr(w, 0), 64'd0));
    endtask

    task automatic build_directed();
        mem_op_e op;
        int      sz;
        int      k;
        k = 0;
        repeat (3) add_row(NO_FETCH, NO_DATA);
        for (int w = 0; w < N_WORDS; w++) begin
            add_row(NO_FETCH, mk_data(1'b0, 1'b1, OP_D, word_addr(w, 0),
                                      fill_pattern(word_addr(w, 0))));
        end
        add_row(NO_FETCH, mk_data(1'b1, 1'b0, OP_D, word_addr(0, 0), 64'd0));
        add_row(NO_FETCH, NO_DATA);
        add_row(mk_fetch(1'b1, word_addr(1, 4)), NO_DATA);
        add_row(NO_FETCH, NO_DATA);
        // Lane merging on one word with junk in the upper data bits.
        store_then_load(OP_B, 4, 1, 64'hffff_ffff_ffff_ffa1);
        store_then_load(OP_BU, 4, 6, 64'h1234_5678_9abc_deb2);
        store_then_load(OP_H, 4, 2, 64'h5555_5555_5555_c3d4);
        store_then_load(OP_HU, 4, 6, 64'haaaa_aaaa_aaaa_e5f6);
        store_then_load(OP_W, 4, 4, 64'h0bad_0bad_7a6b_5c4d);
        add_row(NO_FETCH, mk_data(1'b0, 1'b1, OP_D, word_addr(8, 0), 64'h7061_d2c3_04a5_ff66));
        add_row(NO_FETCH, mk_data(1'b0, 1'b1, OP_D, word_addr(9, 0), 64'h8123_4567_fedc_ba98));
        // Every load opcode at every legal offset while fetches alternate halves.
        for (int w = 8; w < 10; w++) begin
            for (int oc = 0; oc < 7; oc++) begin
                op = mem_op_e'(3'(oc));
                sz = size_bytes(op);
                for (int off = 0; off < 8; off += sz) begin
                    add_row(mk_fetch(1'b1, word_addr(k % N_WORDS, (k % 2) * 4)),
                            mk_data(1'b1, 1'b0, op, word_addr(w, off), 64'd0));
                    k++;
                end
            end
        end
        add_row(mk_fetch(1'b1, `MEM_BASE - 64'd4), NO_DATA);
        add_row(mk_fetch(1'b1, `MEM_BASE + 64'(WINDOW)), NO_DATA);
        add_row(mk_fetch(1'b1, word_addr(2, 2)),
                mk_data(1'b1, 1'b0, OP_H, word_addr(3, 1), 64'd0));
        add_row(NO_FETCH, mk_data(1'b1, 1'b0, OP_W, word_addr(3, 2), 64'd0));
        add_row(NO_FETCH, mk_data(1'b1, 1'b0, OP_D, word_addr(3, 4), 64'd0));
        add_row(NO_FETCH, mk_data(1'b1, 1'b0, OP_WU, word_addr(3, 6), 64'd0));
        add_row(NO_FETCH, mk_data(1'b1, 1'b0, OP_D, `MEM_BASE + 64'(WINDOW), 64'd0));
        add_row(NO_FETCH, mk_data(1'b1, 1'b0, OP_BU, `MEM_BASE - 64'd1, 64'd0));
        add_row(NO_FETCH, mk_data(1'b0, 1'b1, OP_W, word_addr(5, 2), 64'hdead_beef));
        add_row(NO_FETCH, mk_data(1'b0, 1'b1, OP_D, word_addr(5, 4), 64'hdead_beef_dead_beef));
        add_row(NO_FETCH, mk_data(1'b0, 1'b1, OP_H, word_addr(5, 3), 64'hbeef));
        add_row(NO_FETCH, mk_data(1'b0, 1'b1, OP_D, `MEM_BASE + 64'(WINDOW), 64'h1));
        add_row(NO_FETCH, mk_data(1'b0, 1'b1, OP_D, `MEM_BASE - 64'd8, 64'h2));
        add_row(NO_FETCH, mk_data(1'b1, 1'b0, OP_D, word_addr(5, 0), 64'd0));
        add_row(NO_FETCH, mk_data(1'b1, 1'b1, OP_W, word_addr(6, 4), 64'h0102_0304));
        add_row(NO_FETCH, mk_data(1'b1, 1'b0, OP_D, word_addr(6, 0), 64'd0));
    endtask

    task automatic build_random();
        mem_op_e     op;
        int          w;
        int          fw;
        int          kind;
        int          sz;
        int          off;
        logic [63:0] wd;
        for (int n = 0; n < N_RAND; n++) begin
            w    = ($random(seed) & 32'h7fff_ffff) % N_WORDS;
            kind = $random(seed) & 3;
            op   = mem_op_e'(3'(($random(seed) & 32'h7fff_ffff) % 7));
            sz   = size_bytes(op);
            off  = (($random(seed) & 7) / sz) * sz;
            wd   = {$random(seed), $random(seed)};
            fw   = (($random(seed) & 1) != 0) ? w : (($random(seed) & 32'h7fff_ffff) % N_WORDS);
            add_row(mk_fetch(($random(seed) & 3) != 0, word_addr(fw, ($random(seed) & 1) * 4)),
                    mk_data(kind == 1 || kind == 3, kind >= 2, op, word_addr(w, off), wd));
        end
    endtask

    task automatic fail_value(string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_row(row_t r, int n);
        assert (fetch_rsp.valid == r.f_exp.valid && fetch_rsp.error == r.f_exp.error)
            else fail_value($sformatf("row %0d fetch valid/error %0b/%0b, expected %0b/%0b",
                                      n, fetch_rsp.valid, fetch_rsp.error,
                                      r.f_exp.valid, r.f_exp.error));
        if (r.f_exp.valid) begin
            assert (fetch_rsp.instr == r.f_exp.instr)
                else fail_value($sformatf("row %0d instr %h, expected %h",
                                          n, fetch_rsp.instr, r.f_exp.instr));
        end
        assert (data_rsp.valid == r.d_exp.valid && data_rsp.error == r.d_exp.error)
            else fail_value($sformatf("row %0d data valid/error %0b/%0b, expected %0b/%0b",
                                      n, data_rsp.valid, data_rsp.error,
                                      r.d_exp.valid, r.d_exp.error));
        if (r.chk_rdata) begin
            assert (data_rsp.rdata == r.d_exp.rdata)
                else fail_value($sformatf("row %0d rdata %h, expected %h",
                                          n, data_rsp.rdata, r.d_exp.rdata));
        end
    endtask

    initial begin
        seed      = 32'hf94d_2556;
        rst_n     = 1'b0;
        fetch_req = NO_FETCH;
        data_req  = NO_DATA;
        for (int i = 0; i < (1 << `MEM_DEPTH_LOG2); i++) begin
            shadow[i] = 64'd0;
        end
        build_directed();
        build_random();
        cycle_limit = rows.size() + 2 + MARGIN;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_row(rows[i-1], i - 1);
            end
            fetch_req = rows[i].f_req;
            data_req  = rows[i].d_req;
        end
        @(negedge clk);
        check_row(rows[rows.size()-1], rows.size() - 1);
        fetch_req = NO_FETCH;
        data_req  = NO_DATA;
        $display("Everything OK");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
logic/mem_op_pkg.sv
logic/mem_bus_pkg.sv
logic/mem_ctrl.sv
logic/word_ram.sv
logic/read_align.sv
logic/store_merge.sv
logic/mem_subsystem.sv
tb/mem_checker.sv
tb/mem_tb.sv

/* run.sh */
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
if [ $? -ne 0 ]; then
    echo "Could not clean the build directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module mem_tb --Mdir obj_dir -o mem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_sim
if [ $? -ne 0 ]; then
    echo "Simulation ended with a failure status"
    exit 1
fi

exit 0
